//--- source/armIsaPkg.sv
// ARM subset instruction set: encodings, field positions and decode enums
package armIsaPkg;

   localparam int dataWidth    = 32;
   localparam int regAddrWidth = 4;

   typedef logic [31:0] instrWord;

   // Instruction field positions
   localparam int condHi   = 31;
   localparam int condLo   = 28;
   localparam int opHi     = 27;
   localparam int opLo     = 26;
   localparam int immBit   = 25;      // Immediate second operand on data processing
   localparam int functHi  = 24;
   localparam int functLo  = 21;
   localparam int slBit    = 20;      // S for data processing, L for memory
   localparam int rnHi     = 19;
   localparam int rnLo     = 16;
   localparam int rdHi     = 15;
   localparam int rdLo     = 12;
   localparam int rmHi     = 3;
   localparam int rmLo     = 0;
   localparam int imm8Hi   = 7;
   localparam int imm12Hi  = 11;

   // Data processing funct codes
   localparam logic [3:0] functAnd = 4'b0000;
   localparam logic [3:0] functSub = 4'b0010;
   localparam logic [3:0] functAdd = 4'b0100;
   localparam logic [3:0] functOrr = 4'b1100;

   typedef enum logic [1:0] {
      dataProc = 2'b00,
      memory   = 2'b01
   } opClass;

   typedef enum logic [3:0] {
      eq, ne, cs, cc, mi, pl, vs, vc,
      hi, ls, ge, lt, gt, le, al
   } condCode;

   typedef enum logic [1:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOrr
   } aluOp;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } aluFlags;

endpackage

//--- source/armPipePkg.sv
// Pipeline stage register layouts and forwarding select for the ARM core
package armPipePkg;

   import armIsaPkg::*;

   // Control decoded in Decode, carried into Execute
   typedef struct packed {
      logic    regWrite;
      logic    memWrite;
      logic    memToReg;
      logic    aluSrcImm;
      aluOp    op;
      logic    flagWriteNz;
      logic    flagWriteCv;      // Only ADD and SUB touch C and V
      condCode cond;
   } decodeCtrl;

   // Decode/Execute register
   typedef struct packed {
      decodeCtrl                ctrl;
      logic [dataWidth-1:0]     rd1;
      logic [dataWidth-1:0]     rd2;
      logic [dataWidth-1:0]     extImm;
      logic [regAddrWidth-1:0]  ra1;
      logic [regAddrWidth-1:0]  ra2;
      logic [regAddrWidth-1:0]  wa;
   } execStage;

   // Execute/Memory register, controls already gated by the condition
   typedef struct packed {
      logic                     regWrite;
      logic                     memToReg;
      logic                     memWrite;
      logic [dataWidth-1:0]     aluOut;
      logic [dataWidth-1:0]     writeData;
      logic [regAddrWidth-1:0]  wa;
   } memStage;

   // Memory/Writeback register
   typedef struct packed {
      logic                     regWrite;
      logic                     memToReg;
      logic [dataWidth-1:0]     aluOut;
      logic [dataWidth-1:0]     readData;
      logic [regAddrWidth-1:0]  wa;
   } wbStage;

   // Operand source in Execute
   typedef enum logic [1:0] {
      fwdNone = 2'b00,
      fwdWb   = 2'b01,
      fwdMem  = 2'b10
   } forwardSel;

endpackage

//--- source/armRegFile.sv
`timescale 1ns/10ps
// Sixteen-word register file, two combinational reads and one falling-edge write
module armRegFile
(
   input  logic                                clk,
   input  logic                                reset,
   input  logic [armIsaPkg::regAddrWidth-1:0]  ra1,
   input  logic [armIsaPkg::regAddrWidth-1:0]  ra2,
   output logic [armIsaPkg::dataWidth-1:0]     rd1,
   output logic [armIsaPkg::dataWidth-1:0]     rd2,
   input  logic                                we,
   input  logic [armIsaPkg::regAddrWidth-1:0]  wa,
   input  logic [armIsaPkg::dataWidth-1:0]     wd
);
   import armIsaPkg::*;

   logic [dataWidth-1:0] regs [2**regAddrWidth];

   // Mid-cycle write so Decode sees the Writeback value in the same cycle
   always_ff @(negedge clk, posedge reset)
      if (reset)
         regs <= '{default: '0};
      else if (we)
         regs[wa] <= wd;

   assign rd1 = regs[ra1];
   assign rd2 = regs[ra2];

endmodule

//--- source/armFetchDecode.sv
`timescale 1ns/10ps
// Fetch and Decode stages: PC, instruction register, control decode and Decode/Execute register
module armFetchDecode
(
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                stallF,
   input  logic                                stallD,
   input  logic                                flushE,
   output logic [armIsaPkg::dataWidth-1:0]     PCF,
   input  armIsaPkg::instrWord                 InstrF,
   output logic [armIsaPkg::regAddrWidth-1:0]  ra1D,
   output logic [armIsaPkg::regAddrWidth-1:0]  ra2D,
   input  logic [armIsaPkg::dataWidth-1:0]     rd1D,
   input  logic [armIsaPkg::dataWidth-1:0]     rd2D,
   output armPipePkg::execStage                execE
);
   import armIsaPkg::*;
   import armPipePkg::*;

   instrWord             instrD;
   opClass               opD;
   aluOp                 aluOpD;
   decodeCtrl            ctrlD;
   logic [dataWidth-1:0] extImmD;

   // Unknown funct codes fall back to ADD
   function automatic aluOp functToAluOp(logic [3:0] funct);
      case (funct)
         functSub: functToAluOp = aluSub;
         functAnd: functToAluOp = aluAnd;
         functOrr: functToAluOp = aluOrr;
         default:  functToAluOp = aluAdd;
      endcase
   endfunction

   always_ff @(posedge clk, posedge reset)
      if (reset)
         PCF <= '0;
      else if (!stallF)
         PCF <= PCF + dataWidth'(4);

   // Cleared word decodes as ANDEQ, which never passes with flags at zero
   always_ff @(posedge clk, posedge reset)
      if (reset)
         instrD <= '0;
      else if (!stallD)
         instrD <= InstrF;

   assign opD    = opClass'(instrD[opHi:opLo]);
   assign aluOpD = (opD == dataProc) ? functToAluOp(instrD[functHi:functLo]) : aluAdd;

   always_comb
   begin
      ctrlD      = '0;
      ctrlD.cond = condCode'(instrD[condHi:condLo]);
      ctrlD.op   = aluOpD;                          // Loads and stores add the offset
      if (opD == dataProc)
      begin
         ctrlD.regWrite    = 1'b1;
         ctrlD.aluSrcImm   = instrD[immBit];
         ctrlD.flagWriteNz = instrD[slBit];
         ctrlD.flagWriteCv = instrD[slBit] & (aluOpD == aluAdd || aluOpD == aluSub);
      end
      else if (opD == memory)
      begin
         ctrlD.aluSrcImm = 1'b1;
         ctrlD.regWrite  = instrD[slBit];
         ctrlD.memToReg  = instrD[slBit];
         ctrlD.memWrite  = ~instrD[slBit];
      end
   end

   // Stores read the data register through port 2
   assign ra1D = instrD[rnHi:rnLo];
   assign ra2D = (opD == memory && !instrD[slBit]) ? instrD[rdHi:rdLo] : instrD[rmHi:rmLo];

   assign extImmD = (opD == memory) ? {{(dataWidth - imm12Hi - 1){1'b0}}, instrD[imm12Hi:0]}
                                    : {{(dataWidth - imm8Hi - 1){1'b0}}, instrD[imm8Hi:0]};

   always_ff @(posedge clk, posedge reset)
      if (reset)
         execE <= '0;
      else if (flushE)
         execE <= '0;                                // Bubble behind a load-use stall
      else
      begin
         execE.ctrl   <= ctrlD;
         execE.rd1    <= rd1D;
         execE.rd2    <= rd2D;
         execE.extImm <= extImmD;
         execE.ra1    <= ra1D;
         execE.ra2    <= ra2D;
         execE.wa     <= instrD[rdHi:rdLo];
      end

endmodule

//--- source/armExecute.sv
`timescale 1ns/10ps
// Execute stage with forwarding, ALU, condition check and flags, plus Memory and Writeback registers
module armExecute
(
   input  logic                             clk,
   input  logic                             reset,
   input  armPipePkg::execStage             execE,
   input  armPipePkg::forwardSel            forwardA,
   input  armPipePkg::forwardSel            forwardB,
   output armPipePkg::memStage              memM,
   output armPipePkg::wbStage               wbW,
   output logic [armIsaPkg::dataWidth-1:0]  resultW,
   output logic                             MemWrite,
   output logic [armIsaPkg::dataWidth-1:0]  ALUOutM,
   output logic [armIsaPkg::dataWidth-1:0]  WriteDataM,
   input  logic [armIsaPkg::dataWidth-1:0]  ReadDataM
);
   import armIsaPkg::*;
   import armPipePkg::*;

   logic [dataWidth-1:0] srcA;
   logic [dataWidth-1:0] writeDataE;
   logic [dataWidth-1:0] srcB;
   logic                 isSub;
   logic [dataWidth:0]   sum;
   logic [dataWidth-1:0] aluResult;
   aluFlags              aluFlagsE;
   aluFlags              flagsQ;
   logic                 condEx;

   function automatic logic [dataWidth-1:0] pickOperand(forwardSel sel,
                                                        logic [dataWidth-1:0] regVal,
                                                        logic [dataWidth-1:0] memVal,
                                                        logic [dataWidth-1:0] wbVal);
      case (sel)
         fwdMem:  pickOperand = memVal;
         fwdWb:   pickOperand = wbVal;
         default: pickOperand = regVal;
      endcase
   endfunction

   function automatic logic condHolds(condCode cond, aluFlags f);
      logic nEqV;
      nEqV = (f.n == f.v);
      case (cond)
         eq:      condHolds = f.z;
         ne:      condHolds = ~f.z;
         cs:      condHolds = f.c;
         cc:      condHolds = ~f.c;
         mi:      condHolds = f.n;
         pl:      condHolds = ~f.n;
         vs:      condHolds = f.v;
         vc:      condHolds = ~f.v;
         hi:      condHolds = f.c & ~f.z;
         ls:      condHolds = ~f.c | f.z;
         ge:      condHolds = nEqV;
         lt:      condHolds = ~nEqV;
         gt:      condHolds = ~f.z & nEqV;
         le:      condHolds = f.z | ~nEqV;
         al:      condHolds = 1'b1;
         default: condHolds = 1'b0;          // Encoding 1111 never executes
      endcase
   endfunction

   assign srcA       = pickOperand(forwardA, execE.rd1, memM.aluOut, resultW);
   assign writeDataE = pickOperand(forwardB, execE.rd2, memM.aluOut, resultW);
   assign srcB       = execE.ctrl.aluSrcImm ? execE.extImm : writeDataE;

   // Subtract as add of the inverted operand plus one
   assign isSub = (execE.ctrl.op == aluSub);
   assign sum   = {1'b0, srcA} + {1'b0, (isSub ? ~srcB : srcB)} + {{dataWidth{1'b0}}, isSub};

   always_comb
      case (execE.ctrl.op)
         aluAnd:  aluResult = srcA & srcB;
         aluOrr:  aluResult = srcA | srcB;
         default: aluResult = sum[dataWidth-1:0];
      endcase

   assign aluFlagsE.n = aluResult[dataWidth-1];
   assign aluFlagsE.z = (aluResult == '0);
   assign aluFlagsE.c = sum[dataWidth];              // ARM carry, no-borrow on SUB
   assign aluFlagsE.v = ~(srcA[dataWidth-1] ^ srcB[dataWidth-1] ^ isSub)
                        & (srcA[dataWidth-1] ^ sum[dataWidth-1]);

   assign condEx = condHolds(execE.ctrl.cond, flagsQ);

   always_ff @(posedge clk, posedge reset)
      if (reset)
         flagsQ <= '0;
      else
      begin
         if (condEx && execE.ctrl.flagWriteNz)
         begin
            flagsQ.n <= aluFlagsE.n;
            flagsQ.z <= aluFlagsE.z;
         end
         if (condEx && execE.ctrl.flagWriteCv)
         begin
            flagsQ.c <= aluFlagsE.c;
            flagsQ.v <= aluFlagsE.v;
         end
      end

   always_ff @(posedge clk, posedge reset)
      if (reset)
      begin
         memM <= '0;
         wbW  <= '0;
      end
      else
      begin
         memM.regWrite  <= execE.ctrl.regWrite & condEx;
         memM.memWrite  <= execE.ctrl.memWrite & condEx;
         memM.memToReg  <= execE.ctrl.memToReg;
         memM.aluOut    <= aluResult;
         memM.writeData <= writeDataE;
         memM.wa        <= execE.wa;
         wbW.regWrite   <= memM.regWrite;
         wbW.memToReg   <= memM.memToReg;
         wbW.aluOut     <= memM.aluOut;
         wbW.readData   <= ReadDataM;            // Memory answers in the same cycle
         wbW.wa         <= memM.wa;
      end

   assign MemWrite   = memM.memWrite;            // One-cycle store strobe
   assign ALUOutM    = memM.aluOut;
   assign WriteDataM = memM.writeData;

   assign resultW = wbW.memToReg ? wbW.readData : wbW.aluOut;

endmodule

//--- source/armHazardUnit.sv
`timescale 1ns/10ps
// Hazard unit: forwarding selects for Execute and the load-use stall and bubble
module armHazardUnit
(
   input  logic [armIsaPkg::regAddrWidth-1:0]  ra1E,
   input  logic [armIsaPkg::regAddrWidth-1:0]  ra2E,
   input  logic [armIsaPkg::regAddrWidth-1:0]  waE,
   input  logic                                memToRegE,
   input  logic [armIsaPkg::regAddrWidth-1:0]  ra1D,
   input  logic [armIsaPkg::regAddrWidth-1:0]  ra2D,
   input  armPipePkg::memStage                 memM,
   input  armPipePkg::wbStage                  wbW,
   output armPipePkg::forwardSel               forwardA,
   output armPipePkg::forwardSel               forwardB,
   output logic                                stallF,
   output logic                                stallD,
   output logic                                flushE
);
   import armIsaPkg::*;
   import armPipePkg::*;

   logic loadUse;

   // Newest result wins, so Memory is checked before Writeback
   function automatic forwardSel forwardFor(logic [regAddrWidth-1:0] ra,
                                            memStage m,
                                            wbStage w);
      if (m.regWrite && m.wa == ra)
         forwardFor = fwdMem;
      else if (w.regWrite && w.wa == ra)
         forwardFor = fwdWb;
      else
         forwardFor = fwdNone;
   endfunction

   assign forwardA = forwardFor(ra1E, memM, wbW);
   assign forwardB = forwardFor(ra2E, memM, wbW);

   // Load in Execute feeding either Decode source
   assign loadUse = memToRegE & ((waE == ra1D) | (waE == ra2D));

   assign stallF = loadUse;
   assign stallD = loadUse;
   assign flushE = loadUse;

endmodule

//--- source/armCore.sv
`timescale 1ns/10ps
// Five-stage pipelined ARM subset core, top level connecting the stages and hazard unit
module armCore
(
   input  logic                             clk,
   input  logic                             reset,
   output logic [armIsaPkg::dataWidth-1:0]  PCF,
   input  armIsaPkg::instrWord              InstrF,
   output logic                             MemWrite,
   output logic [armIsaPkg::dataWidth-1:0]  ALUOutM,
   output logic [armIsaPkg::dataWidth-1:0]  WriteDataM,
   input  logic [armIsaPkg::dataWidth-1:0]  ReadDataM
);
   import armIsaPkg::*;
   import armPipePkg::*;

   logic [regAddrWidth-1:0] ra1D;
   logic [regAddrWidth-1:0] ra2D;
   logic [dataWidth-1:0]    rd1D;
   logic [dataWidth-1:0]    rd2D;
   execStage                execE;
   memStage                 memM;
   wbStage                  wbW;
   logic [dataWidth-1:0]    resultW;
   forwardSel               forwardA;
   forwardSel               forwardB;
   logic                    stallF;
   logic                    stallD;
   logic                    flushE;

   armFetchDecode fetchDecode (
      .clk    (clk),
      .reset  (reset),
      .stallF (stallF),
      .stallD (stallD),
      .flushE (flushE),
      .PCF    (PCF),
      .InstrF (InstrF),
      .ra1D   (ra1D),
      .ra2D   (ra2D),
      .rd1D   (rd1D),
      .rd2D   (rd2D),
      .execE  (execE)
   );

   // Written from Writeback on the falling edge
   armRegFile regFile (
      .clk   (clk),
      .reset (reset),
      .ra1   (ra1D),
      .ra2   (ra2D),
      .rd1   (rd1D),
      .rd2   (rd2D),
      .we    (wbW.regWrite),
      .wa    (wbW.wa),
      .wd    (resultW)
   );

   armExecute execute (
      .clk        (clk),
      .reset      (reset),
      .execE      (execE),
      .forwardA   (forwardA),
      .forwardB   (forwardB),
      .memM       (memM),
      .wbW        (wbW),
      .resultW    (resultW),
      .MemWrite   (MemWrite),
      .ALUOutM    (ALUOutM),
      .WriteDataM (WriteDataM),
      .ReadDataM  (ReadDataM)
   );

   armHazardUnit hazardUnit (
      .ra1E      (execE.ra1),
      .ra2E      (execE.ra2),
      .waE       (execE.wa),
      .memToRegE (execE.ctrl.memToReg),
      .ra1D      (ra1D),
      .ra2D      (ra2D),
      .memM      (memM),
      .wbW       (wbW),
      .forwardA  (forwardA),
      .forwardB  (forwardB),
      .stallF    (stallF),
      .stallD    (stallD),
      .flushE    (flushE)
   );

endmodule

//--- test/armCore_assertions.sv
`timescale 1ns/10ps
// Concurrent protocol checks on the ARM core store strobe and fetch address
module armCore_assertions
(
   input logic        clk,
   input logic        reset,
   input logic [31:0] PCF,
   input logic        MemWrite
);

   int violations = 0;                 // Count of failed assertions

   strobeKnown: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(MemWrite))
   else
   begin
      $error("MemWrite is unknown");
      violations++;
   end

   // Fetch moves one word forward or stalls
   pcStep: assert property (@(posedge clk) disable iff (reset)
      (PCF == $past(PCF) + 32'd4) || (PCF == $past(PCF)))
   else
   begin
      $error("PCF moved to %h, not one word on from the previous cycle", PCF);
      violations++;
   end

   // A load-use stall lasts a single cycle
   singleHold: assert property (@(posedge clk) disable iff (reset)
      (PCF == $past(PCF)) |=> (PCF != $past(PCF)))
   else
   begin
      $error("PCF held for more than one cycle at %h", PCF);
      violations++;
   end

endmodule

//--- test/armCoreChecker.sv
`timescale 1ns/10ps
// Store and fetch monitor for the ARM core, compares stores against the expected table
module armCoreChecker
#(
   parameter int numStores = 15,
   parameter int numTests  = 5,
   parameter int expHolds  = 1
)
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        MemWrite,
   input  logic [31:0]                 ALUOutM,
   input  logic [31:0]                 WriteDataM,
   input  logic [31:0]                 PCF,
   input  logic [numStores-1:0][67:0]  expStores,   // {test, address, data}
   output int                          errorCount,
   output int                          storesSeen,
   output int                          testsPassed,
   output int                          testsFailed
);

   int          testErrs [numTests+1];
   int          edges;
   int          holds;
   logic [31:0] prevPc;
   logic        pcAtReset;

   function automatic string testName(int t);
      case (t)
         1:       testName = "reset state";
         2:       testName = "ALU ops and forwarding";
         3:       testName = "load-use stall";
         4:       testName = "flags and conditional stores";
         default: testName = "failed condition and flag hold";
      endcase
   endfunction

   task automatic finishTest(int t);
      if (testErrs[t] == 0)
      begin
         testsPassed++;
         $display("test %0d (%s): passed", t, testName(t));
      end
      else
      begin
         testsFailed++;
         $display("test %0d (%s): failed with %0d errors", t, testName(t), testErrs[t]);
      end
   endtask

   initial
   begin
      errorCount  = 0;
      storesSeen  = 0;
      testsPassed = 0;
      testsFailed = 0;
      edges       = 0;
      holds       = 0;
      prevPc      = '0;
      pcAtReset   = 1'b0;
      foreach (testErrs[i])
         testErrs[i] = 0;
   end

   always @(posedge clk)
      if (!reset)
         edges++;

   always @(negedge reset)
      pcAtReset = (PCF == 32'd0) && (MemWrite == 1'b0);

   // Outputs settle after the rising edge, so sample on the falling one
   always @(negedge clk)
   begin
      logic [67:0] row;
      int          t;
      if (!reset)
      begin
         if (edges > 0 && PCF == prevPc)      // PC of zero before the first edge is no stall
            holds++;
         prevPc = PCF;
         if ($isunknown(MemWrite))
         begin
            $display("MemWrite is unknown at time %0t", $time);
            errorCount++;
         end
         else if (MemWrite)
         begin
            if (storesSeen == 0)
            begin
               // First store instruction is fetched at PC 32, reaches Memory three edges on
               if (!pcAtReset || edges != 11)
               begin
                  $display("[FAIL] %0t first store after %0d edges, expected 11, reset PC ok %0b",
                           $time, edges, pcAtReset);
                  errorCount++;
                  testErrs[1]++;
               end
               finishTest(1);
            end
            if (storesSeen >= numStores)
            begin
               $display("unexpected extra store to %h with data %h at time %0t",
                        ALUOutM, WriteDataM, $time);
               errorCount++;
            end
            else
            begin
               row = expStores[storesSeen];
               t   = int'(row[67:64]);
               if (ALUOutM !== row[63:32] || WriteDataM !== row[31:0])
               begin
                  $display("[FAIL] %0t store %0d got %h <- %h, expected %h <- %h", $time,
                           storesSeen, ALUOutM, WriteDataM, row[63:32], row[31:0]);
                  errorCount++;
                  testErrs[t]++;
               end
               if (t == 3 && holds != expHolds)
               begin
                  $display("[FAIL] %0t PCF held %0d cycles, expected %0d", $time, holds, expHolds);
                  errorCount++;
                  testErrs[t]++;
               end
               storesSeen++;
               if (storesSeen == numStores)
                  finishTest(t);
               else if (int'(expStores[storesSeen][67:64]) != t)
                  finishTest(t);
            end
         end
      end
   end

endmodule

//--- test/armCoreTb.sv
`timescale 1ns/10ps
// Testbench for the pipelined ARM core with program and data memory models
module armCoreTb;
   import armIsaPkg::*;

   localparam int progLen    = 36;
   localparam int numStores  = 15;
   localparam int cycleLimit = 4 * (progLen + 30);
   localparam logic [31:0] endPc   = 32'(4 * (progLen + 6));   // Last store has drained
   localparam logic [31:0] nopWord = 32'hE080_0000;            // ADD R0,R0,R0

   logic                       clk;
   logic                       reset;
   logic [31:0]                PCF;
   instrWord                   InstrF;
   logic                       MemWrite;
   logic [31:0]                ALUOutM;
   logic [31:0]                WriteDataM;
   logic [31:0]                ReadDataM;
   logic [31:0]                progMem [progLen];
   logic [31:0]                dataMem [256];
   logic [numStores-1:0][67:0] expStores;
   int                         cycles;
   int                         errorCount;
   int                         storesSeen;
   int                         testsPassed;
   int                         testsFailed;
   int                         totalErrors;

   function automatic instrWord dpImm(condCode c, logic [3:0] f, logic s, logic [3:0] rn,
                                      logic [3:0] rd, logic [7:0] imm);
      dpImm = {4'(c), 2'b00, 1'b1, f, s, rn, rd, 4'h0, imm};
   endfunction

   function automatic instrWord dpReg(condCode c, logic [3:0] f, logic s, logic [3:0] rn,
                                      logic [3:0] rd, logic [3:0] rm);
      dpReg = {4'(c), 2'b00, 1'b0, f, s, rn, rd, 8'h00, rm};
   endfunction

   function automatic instrWord memOp(condCode c, logic l, logic [3:0] rd, logic [11:0] off);
      memOp = {4'(c), 2'b01, 1'b0, 4'b1100, l, 4'd0, rd, off};   // Base is always R0
   endfunction

   armCore uut (
      .clk        (clk),
      .reset      (reset),
      .PCF        (PCF),
      .InstrF     (InstrF),
      .MemWrite   (MemWrite),
      .ALUOutM    (ALUOutM),
      .WriteDataM (WriteDataM),
      .ReadDataM  (ReadDataM)
   );

   bind armCore armCore_assertions coreAsserts (
      .clk      (clk),
      .reset    (reset),
      .PCF      (PCF),
      .MemWrite (MemWrite)
   );

   armCoreChecker #(.numStores(numStores), .numTests(5), .expHolds(1)) storeCheck (
      .clk         (clk),
      .reset       (reset),
      .MemWrite    (MemWrite),
      .ALUOutM     (ALUOutM),
      .WriteDataM  (WriteDataM),
      .PCF         (PCF),
      .expStores   (expStores),
      .errorCount  (errorCount),
      .storesSeen  (storesSeen),
      .testsPassed (testsPassed),
      .testsFailed (testsFailed)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
      if (!reset)
         cycles++;

   // Memory models answer 1 ns after the edge, stores land first
   always @(posedge clk)
   begin
      int idx;
      #1;
      if (!reset && MemWrite)
         dataMem[ALUOutM[9:2]] = WriteDataM;
      idx = int'(PCF[31:2]);
      InstrF    = (idx < progLen) ? progMem[idx] : nopWord;
      ReadDataM = dataMem[ALUOutM[9:2]];
   end

   initial
   begin
      reset     = 1'b1;
      InstrF    = nopWord;
      ReadDataM = '0;
      cycles    = 0;
      for (int i = 0; i < 256; i++)
         dataMem[i] = 32'hC0DE_0000 ^ 32'(i * 4);
      // Test 2, chained ALU ops
      progMem[0]  = dpImm(al, functAdd, 1'b0, 4'd0, 4'd1, 8'h05);   // R1 = 5
      progMem[1]  = dpImm(al, functAdd, 1'b0, 4'd1, 4'd2, 8'h03);   // R2 = 8
      progMem[2]  = dpReg(al, functSub, 1'b0, 4'd2, 4'd3, 4'd1);    // R3 = 3
      progMem[3]  = dpImm(al, functOrr, 1'b0, 4'd3, 4'd4, 8'h30);   // R4 = 0x33
      progMem[4]  = dpReg(al, functAnd, 1'b0, 4'd4, 4'd5, 4'd3);    // R5 = 3
      progMem[5]  = dpReg(al, functOrr, 1'b0, 4'd5, 4'd6, 4'd1);    // R6 = 7
      progMem[6]  = dpImm(al, functSub, 1'b0, 4'd6, 4'd7, 8'h01);   // R7 = 6
      progMem[7]  = dpReg(al, functAdd, 1'b0, 4'd7, 4'd8, 4'd6);    // R8 = 13
      progMem[8]  = memOp(al, 1'b0, 4'd8, 12'h100);
      progMem[9]  = memOp(al, 1'b0, 4'd5, 12'h104);
      progMem[10] = memOp(al, 1'b0, 4'd4, 12'h108);
      progMem[11] = dpImm(al, functAnd, 1'b0, 4'd4, 4'd9, 8'h0F);   // R9 = 3
      progMem[12] = memOp(al, 1'b0, 4'd9, 12'h10C);
      // Test 3, load then dependent add
      progMem[13] = memOp(al, 1'b1, 4'd10, 12'h200);                 // R10 = C0DE0200
      progMem[14] = dpImm(al, functAdd, 1'b0, 4'd10, 4'd11, 8'h22);
      progMem[15] = memOp(al, 1'b0, 4'd11, 12'h110);
      // Test 4, flags
      progMem[16] = dpImm(al, functSub, 1'b1, 4'd1, 4'd12, 8'h05);  // Z C set
      progMem[17] = memOp(eq, 1'b0, 4'd1, 12'h120);
      progMem[18] = memOp(ne, 1'b0, 4'd2, 12'h124);
      progMem[19] = dpReg(al, functAdd, 1'b1, 4'd10, 4'd13, 4'd10); // N C, no V
      progMem[20] = memOp(cs, 1'b0, 4'd13, 12'h128);
      progMem[21] = memOp(vs, 1'b0, 4'd1, 12'h12C);
      progMem[22] = memOp(lt, 1'b0, 4'd2, 12'h130);
      progMem[23] = memOp(ge, 1'b0, 4'd3, 12'h134);
      progMem[24] = dpReg(al, functAdd, 1'b1, 4'd13, 4'd14, 4'd13); // C and V
      progMem[25] = memOp(vs, 1'b0, 4'd14, 12'h138);
      progMem[26] = memOp(ge, 1'b0, 4'd1, 12'h13C);
      progMem[27] = memOp(lt, 1'b0, 4'd3, 12'h140);
      progMem[28] = dpImm(al, functAnd, 1'b1, 4'd1, 4'd9, 8'h00);   // Z, keeps C V
      progMem[29] = memOp(cs, 1'b0, 4'd1, 12'h144);
      progMem[30] = memOp(vs, 1'b0, 4'd2, 12'h148);
      progMem[31] = memOp(eq, 1'b0, 4'd3, 12'h14C);
      // Test 5, skipped write and flag hold
      progMem[32] = dpImm(ne, functAdd, 1'b0, 4'd1, 4'd1, 8'h40);
      progMem[33] = dpImm(al, functAdd, 1'b0, 4'd2, 4'd2, 8'h01);   // R2 = 9, no S
      progMem[34] = memOp(al, 1'b0, 4'd1, 12'h150);
      progMem[35] = memOp(eq, 1'b0, 4'd2, 12'h154);                 // Z still set
      // Hand-computed stores, {test, address, data}
      expStores[0]  = {4'd2, 32'h100, 32'h0000_000D};
      expStores[1]  = {4'd2, 32'h104, 32'h0000_0003};
      expStores[2]  = {4'd2, 32'h108, 32'h0000_0033};
      expStores[3]  = {4'd2, 32'h10C, 32'h0000_0003};
      expStores[4]  = {4'd3, 32'h110, 32'hC0DE_0222};
      expStores[5]  = {4'd4, 32'h120, 32'h0000_0005};
      expStores[6]  = {4'd4, 32'h128, 32'h81BC_0400};
      expStores[7]  = {4'd4, 32'h130, 32'h0000_0008};
      expStores[8]  = {4'd4, 32'h138, 32'h0378_0800};
      expStores[9]  = {4'd4, 32'h140, 32'h0000_0003};
      expStores[10] = {4'd4, 32'h144, 32'h0000_0005};
      expStores[11] = {4'd4, 32'h148, 32'h0000_0008};
      expStores[12] = {4'd4, 32'h14C, 32'h0000_0003};
      expStores[13] = {4'd5, 32'h150, 32'h0000_0005};
      expStores[14] = {4'd5, 32'h154, 32'h0000_0009};

      repeat (10) @(posedge clk);
      #1 reset = 1'b0;
      while (PCF < endPc && cycles < cycleLimit)
         @(negedge clk);
      if (cycles >= cycleLimit)
      begin
         $display("timeout: PCF stuck at %h after %0d cycles", PCF, cycles);
         $display("=== FAIL ===");
      end
      else
      begin
         repeat (2) @(negedge clk);
         totalErrors = errorCount + uut.coreAsserts.violations;
         if (storesSeen < numStores)
         begin
            $display("missing stores: saw %0d of %0d", storesSeen, numStores);
            totalErrors++;
         end
         $display("tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed,
                  totalErrors);
         if (totalErrors == 0 && testsFailed == 0)
            $display("=== PASS ===");
         else
            $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

//--- project.f
source/armIsaPkg.sv
source/armPipePkg.sv
source/armRegFile.sv
source/armFetchDecode.sv
source/armExecute.sv
source/armHazardUnit.sv
source/armCore.sv
test/armCore_assertions.sv
test/armCoreChecker.sv
test/armCoreTb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = armCoreTb
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
